// File: common/clock_pkg.sv
package clock_pkg;

    // --------------------
    // Widths
    // --------------------

    localparam int DIV_W      = 8;
    localparam int OVERSAMPLE = 16;

    typedef logic [3:0]       addr_t;
    typedef logic [3:0]       reg_data_t;
    typedef logic [2:0]       baud_code_t;
    typedef logic [3:0]       phase_t;
    typedef logic [DIV_W-1:0] div_t;

    // --------------------
    // Register map
    // --------------------

    localparam addr_t ADDR_BAUD   = 4'b0001;
    localparam addr_t ADDR_PX_POS = 4'b1110;

    // Data value that turns a request into a read-back
    localparam reg_data_t READ_CODE = 4'b1111;

    localparam baud_code_t BAUD_RESET   = 3'b001;
    localparam phase_t     PX_POS_RESET = 4'b0000;

    // Last phase of a bit period
    localparam phase_t PHASE_LAST = phase_t'(OVERSAMPLE - 1);

    // --------------------
    // Baud rate rule
    // --------------------

    // Code c selects 2**c clocks per oversample tick, 1 up to 128
    function automatic div_t baud_divisor(baud_code_t code);
        div_t one;
        one = div_t'(1);
        return one << code;
    endfunction

endpackage

// File: clock_gen/clock_regfile.sv
`timescale 1ns/1ps

module clock_regfile (
    input  logic                  clk,
    input  logic                  rst,
    input  clock_pkg::addr_t      address,
    input  clock_pkg::reg_data_t  data,
    input  logic                  valid,
    output logic                  ack,
    output clock_pkg::reg_data_t  data_out,
    output logic                  data_out_valid,
    output clock_pkg::baud_code_t baud,
    output clock_pkg::phase_t     px_ratio_pos
);
    import clock_pkg::*;

    logic       ack_ff;
    logic       ack_nxt;
    logic       rd_valid_ff;
    logic       rd_valid_nxt;
    reg_data_t  rd_data_ff;
    reg_data_t  rd_data_nxt;
    baud_code_t baud_ff;
    baud_code_t baud_nxt;
    phase_t     px_pos_ff;
    phase_t     px_pos_nxt;
    logic       busy_ff;
    logic       busy_nxt;

    logic       addr_hit;
    logic       is_read;
    logic       accept;

    // --------------------
    // Request decode
    // --------------------

    assign addr_hit = (address == ADDR_BAUD) || (address == ADDR_PX_POS);
    assign is_read  = (data == READ_CODE);

    // Busy covers the ack cycle, so the next accept is one cycle after it
    assign accept = valid && !busy_ff && addr_hit;

    always_comb begin
        baud_nxt     = baud_ff;
        px_pos_nxt   = px_pos_ff;
        ack_nxt      = 1'b0;
        rd_valid_nxt = 1'b0;
        rd_data_nxt  = '0;
        busy_nxt     = 1'b0;

        if (accept) begin
            ack_nxt  = 1'b1;
            busy_nxt = 1'b1;

            if (is_read) begin
                rd_valid_nxt = 1'b1;
                // Baud code comes back zero-extended
                if (address == ADDR_BAUD) begin
                    rd_data_nxt = reg_data_t'(baud_ff);
                end else begin
                    rd_data_nxt = px_pos_ff;
                end
            end else if (address == ADDR_BAUD) begin
                baud_nxt = baud_code_t'(data);
            end else begin
                px_pos_nxt = data;
            end
        end
    end

    // --------------------
    // State
    // --------------------

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            baud_ff     <= BAUD_RESET;
            px_pos_ff   <= PX_POS_RESET;
            ack_ff      <= 1'b0;
            rd_valid_ff <= 1'b0;
            rd_data_ff  <= '0;
            busy_ff     <= 1'b0;
        end else begin
            baud_ff     <= baud_nxt;
            px_pos_ff   <= px_pos_nxt;
            ack_ff      <= ack_nxt;
            rd_valid_ff <= rd_valid_nxt;
            rd_data_ff  <= rd_data_nxt;
            busy_ff     <= busy_nxt;
        end
    end

    assign ack            = ack_ff;
    assign data_out       = rd_data_ff;
    assign data_out_valid = rd_valid_ff;
    assign baud           = baud_ff;
    assign px_ratio_pos   = px_pos_ff;

endmodule

// File: clock_gen/baud_tick_gen.sv
`timescale 1ns/1ps

module baud_tick_gen (
    input  logic                  clk,
    input  logic                  rst,
    input  clock_pkg::baud_code_t baud,
    output logic                  baud_tick
);
    import clock_pkg::*;

    div_t       cnt_ff;
    div_t       cnt_base;
    div_t       cnt_inc;
    div_t       divisor;
    baud_code_t baud_prev_ff;
    logic       rate_change;
    logic       tick_ff;

    // --------------------
    // Divider
    // --------------------

    assign divisor     = baud_divisor(baud);
    assign rate_change = (baud != baud_prev_ff);

    // A new code counts this cycle as the first one of its period
    assign cnt_base = rate_change ? '0 : cnt_ff;
    assign cnt_inc  = cnt_base + 1'b1;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt_ff       <= '0;
            baud_prev_ff <= BAUD_RESET;
            tick_ff      <= 1'b0;
        end else begin
            baud_prev_ff <= baud;
            if (cnt_inc == divisor) begin
                cnt_ff  <= '0;
                tick_ff <= 1'b1;
            end else begin
                cnt_ff  <= cnt_inc;
                tick_ff <= 1'b0;
            end
        end
    end

    assign baud_tick = tick_ff;

endmodule

// File: clock_gen/sample_phase_gen.sv
`timescale 1ns/1ps

module sample_phase_gen (
    input  logic              clk,
    input  logic              rst,
    input  logic              baud_tick,
    input  clock_pkg::phase_t px_ratio_pos,
    output logic              sample_strobe,
    output logic              bit_strobe
);
    import clock_pkg::*;

    phase_t phase_ff;
    phase_t phase_nxt;
    logic   wrap_hit_ff;
    logic   sample_hit_ff;

    // --------------------
    // Phase counter
    // --------------------

    always_comb begin
        phase_nxt = phase_ff;
        if (baud_tick) begin
            if (phase_ff == PHASE_LAST) begin
                phase_nxt = '0;
            end else begin
                phase_nxt = phase_ff + 1'b1;
            end
        end
    end

    // Compare results for the phase held during the next cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase_ff      <= '0;
            wrap_hit_ff   <= 1'b0;
            sample_hit_ff <= 1'b0;
        end else begin
            phase_ff      <= phase_nxt;
            wrap_hit_ff   <= (phase_nxt == PHASE_LAST);
            sample_hit_ff <= (phase_nxt == px_ratio_pos);
        end
    end

    // --------------------
    // Strobes
    // --------------------

    // Qualified by the tick so they share its cycle
    assign bit_strobe    = baud_tick && wrap_hit_ff;
    assign sample_strobe = baud_tick && sample_hit_ff;

endmodule

// File: rtl/clock_subsys.sv
`timescale 1ns/1ps

module clock_subsys (
    input  logic                 clk,
    input  logic                 rst,
    input  clock_pkg::addr_t     address,
    input  clock_pkg::reg_data_t data,
    input  logic                 valid,
    output logic                 ack,
    output clock_pkg::reg_data_t data_out,
    output logic                 data_out_valid,
    output logic                 baud_tick,
    output logic                 sample_strobe,
    output logic                 bit_strobe
);
    import clock_pkg::*;

    baud_code_t baud;
    phase_t     px_ratio_pos;

    // --------------------
    // Host registers
    // --------------------

    clock_regfile u_regfile (
        .clk            (clk),
        .rst            (rst),
        .address        (address),
        .data           (data),
        .valid          (valid),
        .ack            (ack),
        .data_out       (data_out),
        .data_out_valid (data_out_valid),
        .baud           (baud),
        .px_ratio_pos   (px_ratio_pos)
    );

    // --------------------
    // Timing generators
    // --------------------

    baud_tick_gen u_tick (
        .clk       (clk),
        .rst       (rst),
        .baud      (baud),
        .baud_tick (baud_tick)
    );

    sample_phase_gen u_phase (
        .clk           (clk),
        .rst           (rst),
        .baud_tick     (baud_tick),
        .px_ratio_pos  (px_ratio_pos),
        .sample_strobe (sample_strobe),
        .bit_strobe    (bit_strobe)
    );

endmodule

// File: testbench/tb_clock_subsys.sv
`timescale 1ns/1ps

module tb_clock_subsys;
    import clock_pkg::*;

    localparam int CLK_HALF       = 5;
    localparam int RESET_CYCLES   = 4;
    localparam int ACK_TIMEOUT    = 20;
    localparam int IGNORE_WINDOW  = 10;
    localparam int HOLD_CYCLES    = 6;
    localparam int STROBE_TIMEOUT = 2 * OVERSAMPLE * 128;

    localparam int SEL_TICK   = 0;
    localparam int SEL_SAMPLE = 1;
    localparam int SEL_BIT    = 2;

    logic      clk;
    logic      rst;
    addr_t     address;
    reg_data_t data;
    logic      valid;
    logic      ack;
    reg_data_t data_out;
    logic      data_out_valid;
    logic      baud_tick;
    logic      sample_strobe;
    logic      bit_strobe;

    integer     seed;
    baud_code_t ref_baud;
    phase_t     ref_px_pos;
    logic       exp_rd_valid;
    reg_data_t  exp_rd_data;
    logic       ack_prev;

    clock_subsys u_clock_subsys (
        .clk            (clk),
        .rst            (rst),
        .address        (address),
        .data           (data),
        .valid          (valid),
        .ack            (ack),
        .data_out       (data_out),
        .data_out_valid (data_out_valid),
        .baud_tick      (baud_tick),
        .sample_strobe  (sample_strobe),
        .bit_strobe     (bit_strobe)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    // --------------------
    // Reference model
    // --------------------

    function automatic reg_data_t expected_readback(addr_t addr);
        if (addr == ADDR_BAUD) begin
            return reg_data_t'(ref_baud);
        end
        return ref_px_pos;
    endfunction

    function automatic int expected_tick_spacing(baud_code_t code);
        return int'(baud_divisor(code));
    endfunction

    function automatic int expected_sample_delay(baud_code_t code, phase_t pos);
        return (int'(pos) + 1) * expected_tick_spacing(code);
    endfunction

    function automatic int expected_bit_spacing(baud_code_t code);
        return OVERSAMPLE * expected_tick_spacing(code);
    endfunction

    // --------------------
    // Error reporting
    // --------------------

    task automatic stop_with_fail();
        $display("** FAIL **");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic report_mismatch(string name, int expected, int actual);
        $display("FAILED at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
        stop_with_fail();
    endtask

    task automatic report_error(string msg);
        $display("Error at %0t: %s", $time, msg);
        stop_with_fail();
    endtask

    // Protocol monitor, sampled mid-cycle
    always @(negedge clk) begin
        if (!rst) begin
            assert (!(ack && ack_prev))
            else report_error("ack was high in two consecutive cycles");
            assert (data_out_valid || (data_out == '0))
            else report_mismatch("data_out", 0, int'(data_out));
            assert (!data_out_valid || ack)
            else report_error("data_out_valid was high without ack");
            if (ack) begin
                assert (data_out_valid == exp_rd_valid)
                else report_mismatch("data_out_valid", int'(exp_rd_valid), int'(data_out_valid));
                assert (data_out == exp_rd_data)
                else report_mismatch("data_out", int'(exp_rd_data), int'(data_out));
            end
            ack_prev = ack;
        end
    end

    // --------------------
    // Host requests
    // --------------------

    task automatic send_request(addr_t addr, reg_data_t value);
        int   waited;
        logic got_ack;
        waited  = 0;
        got_ack = 1'b0;
        address = addr;
        data    = value;
        valid   = 1'b1;
        while (!got_ack) begin
            @(negedge clk);
            if (ack) begin
                got_ack = 1'b1;
            end else begin
                waited++;
                if (waited >= ACK_TIMEOUT) begin
                    report_error("ack never came for a register request");
                end
            end
        end
        valid   = 1'b0;
        address = '0;
        data    = '0;
        // Idle cycle after the ack
        @(negedge clk);
    endtask

    task automatic write_reg(addr_t addr, reg_data_t value);
        exp_rd_valid = 1'b0;
        exp_rd_data  = '0;
        send_request(addr, value);
        if (addr == ADDR_BAUD) begin
            ref_baud = baud_code_t'(value);
        end else begin
            ref_px_pos = value;
        end
    endtask

    task automatic read_reg(addr_t addr);
        exp_rd_valid = 1'b1;
        exp_rd_data  = expected_readback(addr);
        send_request(addr, READ_CODE);
        exp_rd_valid = 1'b0;
        exp_rd_data  = '0;
    endtask

    // Valid held high repeats the read once every two cycles
    task automatic held_read(addr_t addr);
        int acks;
        acks         = 0;
        exp_rd_valid = 1'b1;
        exp_rd_data  = expected_readback(addr);
        address      = addr;
        data         = READ_CODE;
        valid        = 1'b1;
        repeat (HOLD_CYCLES) begin
            @(negedge clk);
            if (ack) begin
                acks++;
            end
        end
        valid   = 1'b0;
        address = '0;
        data    = '0;
        assert (acks == HOLD_CYCLES / 2)
        else report_mismatch("ack count", HOLD_CYCLES / 2, acks);
        exp_rd_valid = 1'b0;
        exp_rd_data  = '0;
    endtask

    task automatic request_ignored();
        addr_t addr;
        addr = addr_t'($random(seed));
        while ((addr == ADDR_BAUD) || (addr == ADDR_PX_POS)) begin
            addr = addr_t'($random(seed));
        end
        address = addr;
        data    = reg_data_t'($random(seed));
        valid   = 1'b1;
        repeat (IGNORE_WINDOW) begin
            @(negedge clk);
            assert (!ack) else report_error("ack came for an unmapped address");
        end
        valid   = 1'b0;
        address = '0;
        data    = '0;
    endtask

    // --------------------
    // Strobe timing
    // --------------------

    function automatic logic strobe_level(int sel);
        case (sel)
            SEL_TICK:   return baud_tick;
            SEL_SAMPLE: return sample_strobe;
            default:    return bit_strobe;
        endcase
    endfunction

    function automatic string strobe_name(int sel);
        case (sel)
            SEL_TICK:   return "baud_tick";
            SEL_SAMPLE: return "sample_strobe";
            default:    return "bit_strobe";
        endcase
    endfunction

    // Clocks until the next cycle with the strobe high
    task automatic wait_strobe(int sel, output int cycles);
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > STROBE_TIMEOUT) begin
                report_error({strobe_name(sel), " never came"});
            end
        end while (!strobe_level(sel));
        cycles = n;
    endtask

    initial begin
        int        gap;
        addr_t     addr;
        reg_data_t value;
        phase_t    pos;

        seed       = 20181;
        rst        = 1'b1;
        address    = '0;
        data       = '0;
        valid      = 1'b0;
        ref_baud   = BAUD_RESET;
        ref_px_pos = PX_POS_RESET;
        exp_rd_valid = 1'b0;
        exp_rd_data  = '0;
        ack_prev     = 1'b0;

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        assert (!ack && !data_out_valid && !baud_tick && !sample_strobe && !bit_strobe)
        else report_error("outputs were not low during reset");
        rst = 1'b0;

        // Reset values
        read_reg(ADDR_BAUD);
        read_reg(ADDR_PX_POS);

        // Random write and read-back, READ_CODE excluded from write data
        repeat (12) begin
            addr  = ($random(seed) & 1) ? ADDR_BAUD : ADDR_PX_POS;
            value = reg_data_t'($unsigned($random(seed)) % 15);
            write_reg(addr, value);
            read_reg(ADDR_BAUD);
            read_reg(ADDR_PX_POS);
        end

        repeat (4) request_ignored();
        held_read(ADDR_PX_POS);
        read_reg(ADDR_BAUD);

        // Tick period per baud code
        for (int code = 0; code <= 4; code++) begin
            write_reg(ADDR_BAUD, reg_data_t'(code));
            wait_strobe(SEL_TICK, gap);
            repeat (3) begin
                wait_strobe(SEL_TICK, gap);
                assert (gap == expected_tick_spacing(ref_baud))
                else report_mismatch("baud_tick spacing", expected_tick_spacing(ref_baud), gap);
            end
        end

        // Sample position at a fixed rate
        write_reg(ADDR_BAUD, 4'd2);
        repeat (6) begin
            pos = phase_t'($unsigned($random(seed)) % 15);
            write_reg(ADDR_PX_POS, pos);
            wait_strobe(SEL_BIT, gap);
            wait_strobe(SEL_BIT, gap);
            assert (gap == expected_bit_spacing(ref_baud))
            else report_mismatch("bit_strobe spacing", expected_bit_spacing(ref_baud), gap);
            wait_strobe(SEL_SAMPLE, gap);
            assert (gap == expected_sample_delay(ref_baud, ref_px_pos))
            else report_mismatch("sample_strobe delay",
                                 expected_sample_delay(ref_baud, ref_px_pos), gap);
        end

        read_reg(ADDR_PX_POS);
        repeat (2) @(negedge clk);
        $display("** PASS **");
        $finish;
    end

endmodule

// File: compile.f
common/clock_pkg.sv
clock_gen/clock_regfile.sv
clock_gen/baud_tick_gen.sv
clock_gen/sample_phase_gen.sv
rtl/clock_subsys.sv
testbench/tb_clock_subsys.sv

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=sim_tb
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_clock_subsys \
    -f compile.f \
    --Mdir "$BUILD_DIR" -o "$SIM_BIN"
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -F -x -q "** PASS **" "$LOG"; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation did not pass, see $LOG"
    exit 1
fi
